//--- common/bdWordPkg.sv
// ------------------------------------------------------------
// Host pipe and chip word formats
// ------------------------------------------------------------
package bdWordPkg;

  // Top two bits of every pipe-in word
  typedef enum logic [1:0] {
    chipWord  = 2'b00,
    reserved  = 2'b01,
    regWrite  = 2'b10,
    chanWrite = 2'b11
  } hostTagT;

  // Raw 32-bit pipe-in word
  typedef struct packed {
    hostTagT     tag;
    logic [29:0] body;
  } hostWordT;

  // Body of a register or channel write
  // Channel writes only use id[4:0]
  typedef struct packed {
    logic [5:0]  id;
    logic [7:0]  pad;
    logic [15:0] data;
  } cfgBodyT;

  // Downstream chip word, payload of the down FIFO
  typedef struct packed {
    logic [5:0]  leaf;
    logic [23:0] payload;
  } bdDownWordT;

  // Upstream chip word, payload of the up FIFO
  typedef struct packed {
    logic [9:0]  upper;
    logic [23:0] lower;
  } bdUpWordT;

  // Marker at the top of both pipe-out halves
  localparam logic [7:0] upTag = 8'hff;

endpackage

//--- common/bdRegPkg.sv
// ------------------------------------------------------------
// Configuration register map
// ------------------------------------------------------------
package bdRegPkg;

  typedef logic [5:0]  regIdT;
  typedef logic [15:0] regDataT;

  // Decoded register write, one-cycle strobe
  typedef struct packed {
    logic    strobe;
    regIdT   id;
    regDataT data;
  } regWriteT;

  // Channel value update pulse
  typedef struct packed {
    logic       strobe;
    logic [4:0] chan;
    regDataT    data;
  } chanUpdateT;

  // Only the low half of the id space is backed by flops
  localparam int    numRegs  = 32;
  localparam regIdT regGap   = 6'd1;
  localparam regIdT regReset = 6'd31;
  localparam regIdT regNop   = 6'd63;

  // Words in flight per direction
  localparam int fifoDepth = 16;

endpackage

//--- fifo/wordFifo.sv
`timescale 1ns/10ps

module wordFifo #(
  parameter type payloadT = logic [31:0],
  parameter int  depth    = 16
) (
  input  logic    okClk,
  input  logic    arstN,
  input  logic    push,
  input  payloadT pushData,
  input  logic    pop,
  output payloadT popData,
  output logic    full,
  output logic    empty
);

  localparam int ptrW = $clog2(depth);
  localparam logic [ptrW-1:0] lastPtr = ptrW'(depth - 1);

  payloadT         mem [depth];
  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [ptrW:0]   count;
  logic            doPush;
  logic            doPop;

  // Push while full is dropped
  assign doPush = push && !full;
  assign doPop  = pop && !empty;

  // Storage
  always_ff @(posedge okClk) begin
    if (doPush) begin
      mem[wrPtr] <= pushData;
    end
  end

  // ------------------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------------------
  always_ff @(posedge okClk or negedge arstN) begin
    if (!arstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= (wrPtr == lastPtr) ? '0 : wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= (rdPtr == lastPtr) ? '0 : rdPtr + 1'b1;
      end
      count <= count + {{ptrW{1'b0}}, doPush} - {{ptrW{1'b0}}, doPop};
    end
  end

  // Head word shown without a read cycle
  assign popData = mem[rdPtr];
  assign full    = (count == (ptrW + 1)'(depth));
  assign empty   = (count == '0);

endmodule

//--- hdl/pipeInDecoder.sv
`timescale 1ns/10ps

module pipeInDecoder (
  input  logic                  okClk,
  input  logic                  arstN,
  input  logic                  pipeInWrite,
  input  bdWordPkg::hostWordT   pipeInData,
  output logic                  downPush,
  output bdWordPkg::bdDownWordT downWord,
  output bdRegPkg::regWriteT    regWrite,
  output bdRegPkg::chanUpdateT  chanUpdate
);

  logic              pushQ;
  logic              regStrobeQ;
  logic              chanStrobeQ;
  logic [29:0]       bodyQ;
  bdWordPkg::cfgBodyT cfgIn;
  bdWordPkg::cfgBodyT cfgQ;
  logic              regOk;

  // Register view of the incoming body
  assign cfgIn = bdWordPkg::cfgBodyT'(pipeInData.body);

  // Padding writes and ids above the file are dropped
  assign regOk = (cfgIn.id != bdRegPkg::regNop) &&
                 (cfgIn.id < bdRegPkg::regIdT'(bdRegPkg::numRegs));

  // ------------------------------------------------------------
  // Strobes, sorted by tag
  // ------------------------------------------------------------
  always_ff @(posedge okClk or negedge arstN) begin
    if (!arstN) begin
      pushQ       <= 1'b0;
      regStrobeQ  <= 1'b0;
      chanStrobeQ <= 1'b0;
    end else begin
      pushQ       <= pipeInWrite && (pipeInData.tag == bdWordPkg::chipWord);
      regStrobeQ  <= pipeInWrite && (pipeInData.tag == bdWordPkg::regWrite) && regOk;
      chanStrobeQ <= pipeInWrite && (pipeInData.tag == bdWordPkg::chanWrite);
    end
  end

  // Body held for whichever path fires
  always_ff @(posedge okClk) begin
    if (pipeInWrite) begin
      bodyQ <= pipeInData.body;
    end
  end

  assign cfgQ     = bdWordPkg::cfgBodyT'(bodyQ);
  assign downPush = pushQ;
  assign downWord = bdWordPkg::bdDownWordT'(bodyQ);

  assign regWrite   = '{strobe: regStrobeQ, id: cfgQ.id, data: cfgQ.data};
  assign chanUpdate = '{strobe: chanStrobeQ, chan: cfgQ.id[4:0], data: cfgQ.data};

endmodule

//--- hdl/configRegs.sv
`timescale 1ns/10ps

module configRegs (
  input  logic               okClk,
  input  logic               arstN,
  input  bdRegPkg::regWriteT regWrite,
  output logic [15:0]        gapCycles,
  output logic               bdReset
);

  localparam int idxW = $clog2(bdRegPkg::numRegs);

  // Indices trimmed to the implemented range
  localparam logic [idxW-1:0] gapIdx   = idxW'(bdRegPkg::regGap);
  localparam logic [idxW-1:0] resetIdx = idxW'(bdRegPkg::regReset);

  bdRegPkg::regDataT regFile [bdRegPkg::numRegs];
  logic [idxW-1:0]   wrIdx;

  // Decoder already filtered out-of-range ids
  assign wrIdx = regWrite.id[idxW-1:0];

  // ------------------------------------------------------------
  // Register file
  // ------------------------------------------------------------
  always_ff @(posedge okClk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < bdRegPkg::numRegs; i++) begin
        regFile[i] <= '0;
      end
      // Chip starts held in reset
      regFile[resetIdx] <= 16'h0001;
    end else if (regWrite.strobe) begin
      regFile[wrIdx] <= regWrite.data;
    end
  end

  // ------------------------------------------------------------
  // Fields used by the bridge
  // ------------------------------------------------------------

  // Idle cycles between downstream words
  assign gapCycles = regFile[gapIdx];

  // Chip reset, bit 0 of register 31
  assign bdReset = regFile[resetIdx][0];

endmodule

//--- hdl/pacingTimer.sv
`timescale 1ns/10ps

module pacingTimer (
  input  logic        okClk,
  input  logic        arstN,
  input  logic        start,
  input  logic [15:0] gapCycles,
  output logic        gapDone
);

  logic [15:0] count;

  // ------------------------------------------------------------
  // Gap counter
  // ------------------------------------------------------------

  // Reload on each accepted chip word
  // Valid stays low while nonzero
  always_ff @(posedge okClk or negedge arstN) begin
    if (!arstN) begin
      count <= '0;
    end else if (start) begin
      count <= gapCycles;
    end else if (count != '0) begin
      count <= count - 16'd1;
    end
  end

  // Zero gap gives back-to-back transfers
  assign gapDone = (count == '0);

endmodule

//--- hdl/upstreamSerializer.sv
`timescale 1ns/10ps

module upstreamSerializer (
  input  logic                okClk,
  input  logic                arstN,
  input  logic                fifoEmpty,
  input  bdWordPkg::bdUpWordT fifoData,
  input  logic                pipeOutRead,
  output logic                fifoPop,
  output logic [31:0]         pipeOutData,
  output logic                pipeOutAvailable
);

  typedef enum logic [1:0] {
    idle,
    lowHalf,
    highHalf
  } serStateT;

  serStateT            state;
  bdWordPkg::bdUpWordT holdQ;

  // Capture only from idle
  assign fifoPop = (state == idle) && !fifoEmpty;

  // ------------------------------------------------------------
  // Half sequencing
  // ------------------------------------------------------------
  always_ff @(posedge okClk or negedge arstN) begin
    if (!arstN) begin
      state <= idle;
    end else begin
      case (state)
        idle:     if (!fifoEmpty) state <= lowHalf;
        lowHalf:  if (pipeOutRead) state <= highHalf;
        highHalf: if (pipeOutRead) state <= idle;
        default:  state <= idle;
      endcase
    end
  end

  // Chip word held until both halves are read
  always_ff @(posedge okClk) begin
    if (fifoPop) begin
      holdQ <= fifoData;
    end
  end

  // ------------------------------------------------------------
  // Pipe-out word
  // ------------------------------------------------------------

  // Low half first, then tag, padding and bits 33:24
  assign pipeOutData = (state == highHalf) ?
                       {bdWordPkg::upTag, 14'd0, holdQ.upper} :
                       {bdWordPkg::upTag, holdQ.lower};

  assign pipeOutAvailable = (state != idle);

endmodule

//--- hdl/bdHostBridge.sv
`timescale 1ns/10ps

module bdHostBridge (
  input  logic                  okClk,
  input  logic                  arstN,
  input  logic                  pipeInWrite,
  input  bdWordPkg::hostWordT   pipeInData,
  output logic                  pipeInReady,
  input  logic                  pipeOutRead,
  output logic [31:0]           pipeOutData,
  output logic                  pipeOutAvailable,
  output logic                  bdOutValid,
  input  logic                  bdOutReady,
  output bdWordPkg::bdDownWordT bdOutData,
  input  logic                  bdInValid,
  output logic                  bdInReady,
  input  bdWordPkg::bdUpWordT   bdInData,
  output logic                  bdReset,
  output bdRegPkg::chanUpdateT  chanUpdate
);

  logic                  downPush;
  bdWordPkg::bdDownWordT downWord;
  logic                  downFull;
  logic                  downEmpty;
  logic                  downXfer;
  bdRegPkg::regWriteT    cfgWrite;
  logic [15:0]           gapCycles;
  logic                  gapDone;
  logic                  upFull;
  logic                  upEmpty;
  logic                  upPop;
  bdWordPkg::bdUpWordT   upData;

  // ------------------------------------------------------------
  // Downstream path
  // ------------------------------------------------------------
  pipeInDecoder decoder (
    .okClk, .arstN, .pipeInWrite, .pipeInData,
    .downPush, .downWord, .regWrite(cfgWrite), .chanUpdate
  );

  configRegs regs (.okClk, .arstN, .regWrite(cfgWrite), .gapCycles, .bdReset);

  wordFifo #(.payloadT(bdWordPkg::bdDownWordT), .depth(bdRegPkg::fifoDepth)) downFifo (
    .okClk, .arstN, .push(downPush), .pushData(downWord),
    .pop(downXfer), .popData(bdOutData), .full(downFull), .empty(downEmpty)
  );

  // Valid only once the gap has elapsed
  assign bdOutValid  = gapDone && !downEmpty;
  assign downXfer    = bdOutValid && bdOutReady;
  assign pipeInReady = !downFull;

  pacingTimer pacer (.okClk, .arstN, .start(downXfer), .gapCycles, .gapDone);

  // ------------------------------------------------------------
  // Upstream path
  // ------------------------------------------------------------
  assign bdInReady = !upFull;

  wordFifo #(.payloadT(bdWordPkg::bdUpWordT), .depth(bdRegPkg::fifoDepth)) upFifo (
    .okClk, .arstN, .push(bdInValid && bdInReady), .pushData(bdInData),
    .pop(upPop), .popData(upData), .full(upFull), .empty(upEmpty)
  );

  upstreamSerializer serializer (
    .okClk, .arstN, .fifoEmpty(upEmpty), .fifoData(upData), .pipeOutRead,
    .fifoPop(upPop), .pipeOutData, .pipeOutAvailable
  );

endmodule

//--- tb/bdHostBridgeTb.sv
`timescale 1ns/10ps

module bdHostBridgeTb;

  localparam int maxLines = 64;

  logic                  okClk;
  logic                  arstN;
  logic                  pipeInWrite;
  bdWordPkg::hostWordT   pipeInData;
  logic                  pipeInReady;
  logic                  pipeOutRead;
  logic [31:0]           pipeOutData;
  logic                  pipeOutAvailable;
  logic                  bdOutValid;
  logic                  bdOutReady;
  bdWordPkg::bdDownWordT bdOutData;
  logic                  bdInValid;
  logic                  bdInReady;
  bdWordPkg::bdUpWordT   bdInData;
  logic                  bdReset;
  bdRegPkg::chanUpdateT  chanUpdate;

  // Pattern rows of kind, word, expected
  logic [35:0] patMem [0:3*maxLines-1];

  // Expected results in arrival order
  logic [29:0] downQ [$];
  logic [20:0] chanQ [$];
  int          chanCycleQ [$];
  logic [31:0] pipeQ [$];

  int          cycle = 0;
  int          cycleLimit = 0;
  int          gapModel = 0;
  int          gapAtLast = 0;
  int          lastXfer = -1;
  int          b2bCount = 0;
  logic [31:0] rngState = 32'h61e4;

  bdHostBridge dut (.*);

  initial begin
    okClk = 1'b0;
    forever #50 okClk = ~okClk;
  end

  // ------------------------------------------------------------
  // Failure reporting and helpers
  // ------------------------------------------------------------
  task automatic abortRun(input string msg);
    $display("%s at %0t", msg, $time);
    $display("ERRORS FOUND");
    $fatal(1, "stopping at first error");
  endtask

  task automatic expectEqual(input string name, input logic [35:0] expVal,
                             input logic [35:0] actVal);
    assert (actVal === expVal) else begin
      $display("FAIL %0t %s expected %h got %h", $time, name, expVal, actVal);
      $display("ERRORS FOUND");
      $fatal(1, "stopping at first error");
    end
  endtask

  function automatic logic [31:0] nextRand();
    logic [31:0] x;
    x = rngState;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rngState = x;
    return x;
  endfunction

  // Watchdog limit is set once the patterns are counted
  always @(posedge okClk) begin
    cycle = cycle + 1;
    if (cycleLimit != 0 && cycle > cycleLimit) begin
      $display("timeout after %0d cycles, outputs still pending", cycle);
      $display("ERRORS FOUND");
      $fatal(1, "run did not finish in time");
    end
  end

  // ------------------------------------------------------------
  // Output monitors sampled mid-cycle
  // ------------------------------------------------------------
  task automatic scoreDownXfer();
    logic [29:0] expWord;
    assert (downQ.size() != 0) else abortRun("chip word sent downstream with none expected");
    expWord = downQ.pop_front();
    expectEqual("bdOutData", {6'd0, expWord}, {6'd0, bdOutData});
    // Spacing uses the gap loaded at the previous transfer
    if (lastXfer >= 0) begin
      assert (cycle - lastXfer >= gapAtLast + 1) else
        abortRun("downstream transfers closer than the programmed gap");
      if (gapAtLast == 0 && cycle - lastXfer == 1) begin
        b2bCount++;
      end
    end
    lastXfer  = cycle;
    gapAtLast = gapModel;
  endtask

  task automatic matchChanPulse();
    logic [20:0] expChan;
    int          expCycle;
    assert (chanQ.size() != 0) else abortRun("chanUpdate pulse with no channel write pending");
    expChan  = chanQ.pop_front();
    expCycle = chanCycleQ.pop_front();
    expectEqual("chanUpdate", {15'd0, expChan}, {15'd0, chanUpdate.chan, chanUpdate.data});
    expectEqual("chanUpdate cycle", 36'(expCycle), 36'(cycle));
  endtask

  always @(negedge okClk) begin
    if (arstN) begin
      if (bdOutValid && bdOutReady) begin
        scoreDownXfer();
      end
      if (chanUpdate.strobe) begin
        matchChanPulse();
      end
    end
  end

  // ------------------------------------------------------------
  // Chip sink and host reader with one random draw per cycle
  // ------------------------------------------------------------
  initial begin : chipAndHostModels
    logic [31:0] r;
    logic [31:0] expWord;
    bdOutReady  = 1'b0;
    pipeOutRead = 1'b0;
    forever begin
      @(posedge okClk);
      #10;
      r = nextRand();
      // Sink stalls about one cycle in eight
      bdOutReady  = (r[2:0] != 3'd0);
      pipeOutRead = 1'b0;
      if (arstN && pipeOutAvailable && r[9:8] != 2'd0) begin
        assert (pipeQ.size() != 0) else abortRun("pipe-out word shown with none expected");
        expWord = pipeQ.pop_front();
        expectEqual("pipeOutData", {4'd0, expWord}, {4'd0, pipeOutData});
        pipeOutRead = 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // Stimulus entered and left 10 ns after a rising edge
  // ------------------------------------------------------------
  task automatic playHostWord(input logic [31:0] word, input logic [35:0] expVal);
    logic [1:0] tag;
    logic [5:0] id;
    tag = word[31:30];
    id  = word[29:24];
    // Gap changes only while downstream is idle
    if (tag == 2'b10 && id == 6'd1) begin
      while (downQ.size() != 0) begin
        @(posedge okClk);
        #10;
      end
    end
    if (tag == 2'b00) begin
      // Down FIFO cannot be full with fewer words outstanding than its depth
      if (downQ.size() < bdRegPkg::fifoDepth) begin
        expectEqual("pipeInReady", 36'd1, {35'd0, pipeInReady});
      end
      downQ.push_back(expVal[29:0]);
    end
    if (tag == 2'b11) begin
      chanQ.push_back(expVal[20:0]);
      chanCycleQ.push_back(cycle + 1);
    end
    pipeInData  = bdWordPkg::hostWordT'(word);
    pipeInWrite = 1'b1;
    @(posedge okClk);
    #10;
    pipeInWrite = 1'b0;
    if (tag == 2'b10 && (id == 6'd31 || id == 6'd1)) begin
      @(posedge okClk);
      #10;
      if (id == 6'd31) begin
        expectEqual("bdReset", expVal, {35'd0, bdReset});
      end else begin
        gapModel = int'(expVal[15:0]);
      end
    end
  endtask

  task automatic sendChipWord(input logic [33:0] word);
    logic readyNow;
    bdInData  = bdWordPkg::bdUpWordT'(word);
    bdInValid = 1'b1;
    do begin
      readyNow = bdInReady;
      @(posedge okClk);
      #10;
    end while (!readyNow);
    bdInValid = 1'b0;
  endtask

  initial begin : mainSequence
    int          numLines;
    logic [35:0] kind;
    logic [35:0] word;
    logic [35:0] expVal;
    arstN       = 1'b0;
    pipeInWrite = 1'b0;
    pipeInData  = '0;
    bdInValid   = 1'b0;
    bdInData    = '0;
    for (int i = 0; i < 3 * maxLines; i++) begin
      patMem[i] = '0;
    end
    $readmemh("tb/bdPatterns.mem", patMem);
    numLines = 0;
    while (numLines < maxLines &&
           patMem[3*numLines] >= 36'd1 && patMem[3*numLines] <= 36'd3) begin
      numLines++;
    end
    assert (numLines > 0) else abortRun("pattern file missing or empty");
    cycleLimit = 40 * numLines + 200;

    repeat (4) @(posedge okClk);
    #10;
    arstN = 1'b1;
    // Post-reset state
    expectEqual("bdReset", 36'd1, {35'd0, bdReset});
    expectEqual("bdOutValid", 36'd0, {35'd0, bdOutValid});
    expectEqual("pipeOutAvailable", 36'd0, {35'd0, pipeOutAvailable});

    for (int i = 0; i < numLines; i++) begin
      kind   = patMem[3*i];
      word   = patMem[3*i+1];
      expVal = patMem[3*i+2];
      case (kind[1:0])
        2'd1:    playHostWord(word[31:0], expVal);
        2'd2:    sendChipWord(word[33:0]);
        default: pipeQ.push_back(expVal[31:0]);
      endcase
    end

    // Drain everything still expected
    while (downQ.size() != 0 || chanQ.size() != 0 || pipeQ.size() != 0) begin
      @(posedge okClk);
      #10;
    end
    repeat (5) @(posedge okClk);
    #10;
    // A no-op write leaking into register 31 would set this again
    expectEqual("bdReset", 36'd0, {35'd0, bdReset});
    assert (b2bCount > 0) else abortRun("no back-to-back downstream transfers at gap 0");
    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- tb/bdPatterns.mem
// kind word expected: 1 host word, 2 chip up word, 3 expected pipe-out word
// Host expected is the down word, {chan, data} or the register value
1 9F000000 0
1 03123456 03123456
1 2AABCDEF 2AABCDEF
1 3F000001 3F000001
1 00FFFFFF 00FFFFFF
1 11000077 11000077
1 5A5A5A5A 0
1 BF00ABCD 0
1 C5001234 051234
1 81000003 3
1 0C00C0DE 0C00C0DE
1 21FEDCBA 21FEDCBA
1 15000010 15000010
1 D200BEEF 12BEEF
2 3FF00AA55 0
3 0 FF00AA55
3 0 FF0003FF
2 123456789 0
3 0 FF456789
3 0 FF000123
2 280000001 0
3 0 FF000001
3 0 FF000280

//--- src.f
common/bdWordPkg.sv
common/bdRegPkg.sv
fifo/wordFifo.sv
hdl/pipeInDecoder.sv
hdl/configRegs.sv
hdl/pacingTimer.sv
hdl/upstreamSerializer.sv
hdl/bdHostBridge.sv
tb/bdHostBridgeTb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -f src.f --top-module bdHostBridgeTb -o bdHostBridgeSim &&
  ./obj_dir/bdHostBridgeSim ||
  { echo "simulation failed"; exit 1; }
